// File: all.f
logic/lsu_pkg.sv
logic/lsu_ctrl_if.sv
logic/lsu_fsm.sv
logic/lsu_req_align.sv
logic/lsu_rdata_align.sv
logic/lsu_top.sv
dv/lsu_checker.sv
dv/tb_lsu.sv

// File: dv/lsu_checker.sv
// LSU checker: byte-level reference memory and expected results
// bus request, response and reset state comparison, per-test reporting
`timescale 1ns/1ps

module lsu_checker (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        lsu_we_i,
  input  logic [1:0]  lsu_type_i,
  input  logic [31:0] lsu_addr_i,
  input  logic [31:0] lsu_wdata_i,
  input  logic        lsu_sign_ext_i,
  input  logic [31:0] lsu_rdata_o,
  input  logic        lsu_rdata_valid_o,
  input  logic        lsu_req_done_o,
  input  logic        lsu_resp_valid_o,
  input  logic [31:0] addr_last_o,
  input  logic        load_err_o,
  input  logic        store_err_o,
  input  logic        busy_o,
  input  logic        data_req_o,
  input  logic        data_gnt_i,
  input  logic [31:0] data_addr_o,
  input  logic        data_we_o,
  input  logic [3:0]  data_be_o,
  input  logic [31:0] data_wdata_o,
  input  logic        test_end_i,
  input  int          test_num_i,
  output int          check_count_o,
  output int          error_count_o
);

  logic [7:0]  mem_bytes [logic [31:0]];
  // attributes of the access in flight, taken at done
  logic        p_we;
  logic [1:0]  p_type;
  logic [31:0] p_addr;
  logic [31:0] p_wdata;
  logic        p_sext;
  int          gnt_count;
  logic        hold;
  logic [31:0] hold_addr;
  logic        reset_seen;
  int          last_checks;
  int          last_errs;

  initial begin
    check_count_o = 0;
    error_count_o = 0;
    gnt_count     = 0;
    hold          = 1'b0;
    reset_seen    = 1'b0;
    last_checks   = 0;
    last_errs     = 0;
  end

  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return {a[15:0], ~a[31:16]} ^ 32'h6c3a_91e5;
  endfunction

  function automatic logic [7:0] model_byte(input logic [31:0] a);
    logic [31:0] w;
    if (mem_bytes.exists(a)) return mem_bytes[a];
    w = fill_word({a[31:2], 2'b00});
    return w[8*a[1:0] +: 8];
  endfunction

  function automatic int access_size(input logic [1:0] t);
    return (t == 2'd0) ? 4 : (t == 2'd1) ? 2 : 1;
  endfunction

  function automatic logic in_err_region(input logic [31:0] a);
    return a[31:28] == 4'hF;
  endfunction

  // full byte mask for every enabled lane
  function automatic logic [31:0] lane_mask(input logic [3:0] be);
    logic [31:0] m;
    for (int b = 0; b < 4; b++) begin
      m[8*b +: 8] = {8{be[b]}};
    end
    return m;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    check_count_o++;
    if (exp !== got) begin
      $display("[FAIL] %s expected %h got %h", name, exp, got);
      error_count_o++;
    end
  endtask

  always @(posedge clk_i) begin
    int          n;
    int          lane;
    logic        err;
    logic [31:0] v;
    logic [31:0] base;
    logic [3:0]  be;
    logic [31:0] wd;
    if (rst_ni) begin
      // control outputs quiet after reset
      if (!reset_seen) begin
        reset_seen = 1'b1;
        check_val("control outputs after reset", 32'h0,
                  {data_req_o, busy_o, lsu_req_done_o, lsu_resp_valid_o,
                   lsu_rdata_valid_o, load_err_o, store_err_o});
      end

      // a request without grant must stay unchanged
      if (hold) begin
        check_val("data_req_o", 32'h1, {31'h0, data_req_o});
        check_val("data_addr_o held", hold_addr, data_addr_o);
      end
      hold      = data_req_o && !data_gnt_i;
      hold_addr = data_addr_o;

      n    = access_size(lsu_type_i);
      base = {lsu_addr_i[31:2], 2'b00};
      if (data_req_o && data_gnt_i) begin
        be = 4'h0;
        wd = 32'h0;
        for (int i = 0; i < n; i++) begin
          lane = int'(lsu_addr_i[1:0]) + i;
          // lanes past the top byte move to the next word
          if (lane < 4 && gnt_count == 0) begin
            be[lane]        = 1'b1;
            wd[8*lane +: 8] = lsu_wdata_i[8*i +: 8];
          end
          if (lane >= 4 && gnt_count == 1) begin
            be[lane-4]          = 1'b1;
            wd[8*(lane-4) +: 8] = lsu_wdata_i[8*i +: 8];
          end
        end
        check_val("data_addr_o", base + 32'(4 * gnt_count), data_addr_o);
        check_val("data_be_o", {28'h0, be}, {28'h0, data_be_o});
        check_val("data_we_o", {31'h0, lsu_we_i}, {31'h0, data_we_o});
        // only enabled lanes carry store data
        if (lsu_we_i) check_val("data_wdata_o", wd, data_wdata_o & lane_mask(be));
        gnt_count++;
      end

      if (lsu_req_done_o) begin
        check_val("bus requests per access",
                  (int'(lsu_addr_i[1:0]) + n > 4) ? 2 : 1, gnt_count);
        gnt_count = 0;
        p_we      = lsu_we_i;
        p_type    = lsu_type_i;
        p_addr    = lsu_addr_i;
        p_wdata   = lsu_wdata_i;
        p_sext    = lsu_sign_ext_i;
      end

      if (lsu_resp_valid_o) begin
        n   = access_size(p_type);
        err = 1'b0;
        v   = 32'h0;
        for (int i = 0; i < n; i++) begin
          err = err | in_err_region(p_addr + 32'(i));
          v[8*i +: 8] = model_byte(p_addr + 32'(i));
        end
        if (p_sext && n == 2 && v[15]) v[31:16] = 16'hffff;
        if (p_sext && n == 1 && v[7]) v[31:8] = 24'hff_ffff;
        check_val("store_err_o", {31'h0, p_we & err}, {31'h0, store_err_o});
        check_val("load_err_o", {31'h0, !p_we & err}, {31'h0, load_err_o});
        check_val("lsu_rdata_valid_o", {31'h0, !p_we & !err}, {31'h0, lsu_rdata_valid_o});
        if (!p_we && !err) check_val("lsu_rdata_o", v, lsu_rdata_o);
        // first failing part: byte address, else the second word
        if (err) begin
          check_val("addr_last_o", in_err_region(p_addr) ? p_addr :
                    {p_addr[31:2], 2'b00} + 32'd4, addr_last_o);
        end
        // bytes outside the error region are written
        if (p_we) begin
          for (int i = 0; i < n; i++) begin
            if (!in_err_region(p_addr + 32'(i))) mem_bytes[p_addr + 32'(i)] = p_wdata[8*i +: 8];
          end
        end
      end

      if (test_end_i) begin
        $display("test %0d finished: %0d checks, %0d failures", test_num_i,
                 check_count_o - last_checks, error_count_o - last_errs);
        last_checks = check_count_o;
        last_errs   = error_count_o;
      end
    end
  end

endmodule

// File: dv/tb_lsu.sv
// load/store unit testbench top
// clock, reset, random access stimulus per test phase
// memory responder with random grant and response delays
`timescale 1ns/1ps

module tb_lsu;

  localparam logic [31:0] Seed     = 32'h348e_8d4e;
  localparam int          MaxWait  = 200;
  localparam logic [31:0] BaseAddr = 32'h0000_2000;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        lsu_req_i;
  logic        lsu_we_i;
  logic [1:0]  lsu_type_i;
  logic [31:0] lsu_addr_i;
  logic [31:0] lsu_wdata_i;
  logic        lsu_sign_ext_i;
  logic [31:0] lsu_rdata_o;
  logic        lsu_rdata_valid_o;
  logic        lsu_req_done_o;
  logic        lsu_resp_valid_o;
  logic [31:0] addr_last_o;
  logic        load_err_o;
  logic        store_err_o;
  logic        busy_o;
  logic        data_req_o;
  logic        data_gnt_i     = 1'b0;
  logic        data_rvalid_i  = 1'b0;
  logic        data_bus_err_i = 1'b0;
  logic [31:0] data_addr_o;
  logic        data_we_o;
  logic [3:0]  data_be_o;
  logic [31:0] data_wdata_o;
  logic [31:0] data_rdata_i   = 32'h0;

  logic        test_end_i;
  int          test_num_i;
  int          check_count;
  int          error_count;
  logic        timed_out;

  // responder state, one entry per granted request
  logic [31:0] mem [logic [31:0]];
  logic [31:0] q_addr[$];
  logic        q_we[$];
  logic [3:0]  q_be[$];
  logic [31:0] q_wdata[$];
  int          q_delay[$];
  int          gnt_wait;

  always #10 clk_i = ~clk_i;

  lsu_top #(.AddrWidth(32)) UUT (.*);

  lsu_checker u_checker (
    .*,
    .check_count_o (check_count),
    .error_count_o (error_count)
  );

  // untouched words read back a pattern of their own address
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return {a[15:0], ~a[31:16]} ^ 32'h6c3a_91e5;
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] a);
    return mem.exists(a) ? mem[a] : fill_word(a);
  endfunction

  //////////////////////////////
  // memory responder
  //////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    logic [31:0] a;
    logic [31:0] w;
    if (!rst_ni) begin
      data_gnt_i     <= 1'b0;
      data_rvalid_i  <= 1'b0;
      data_bus_err_i <= 1'b0;
      gnt_wait = 0;
      q_addr.delete();
      q_we.delete();
      q_be.delete();
      q_wdata.delete();
      q_delay.delete();
    end else begin
      data_rvalid_i  <= 1'b0;
      data_bus_err_i <= 1'b0;
      if (data_req_o && data_gnt_i) begin
        q_addr.push_back(data_addr_o);
        q_we.push_back(data_we_o);
        q_be.push_back(data_be_o);
        q_wdata.push_back(data_wdata_o);
        q_delay.push_back(1 + int'($urandom % 3));
        gnt_wait = int'($urandom % 4);
        data_gnt_i <= (gnt_wait == 0);
      end else if (data_req_o) begin
        if (gnt_wait > 0) gnt_wait--;
        data_gnt_i <= (gnt_wait == 0);
      end
      // in-order responses, oldest entry counts down first
      if (q_addr.size() > 0) begin
        if (q_delay[0] <= 1) begin
          a = q_addr[0];
          data_rvalid_i <= 1'b1;
          if (a[31:28] == 4'hF) begin
            data_bus_err_i <= 1'b1;
            data_rdata_i   <= 32'hbad0_bad0;
          end else if (q_we[0]) begin
            w = read_word(a);
            for (int b = 0; b < 4; b++) begin
              if (q_be[0][b]) w[8*b +: 8] = q_wdata[0][8*b +: 8];
            end
            mem[a] = w;
          end else begin
            data_rdata_i <= read_word(a);
          end
          void'(q_addr.pop_front());
          void'(q_we.pop_front());
          void'(q_be.pop_front());
          void'(q_wdata.pop_front());
          void'(q_delay.pop_front());
        end else begin
          q_delay[0] = q_delay[0] - 1;
        end
      end
    end
  end

  //////////////////////////////
  // stimulus tasks
  //////////////////////////////

  task automatic run_access(input logic we, input logic [1:0] typ,
                            input logic [31:0] addr, input logic sext);
    int t;
    if (!timed_out) begin
      @(posedge clk_i);
      lsu_req_i      <= 1'b1;
      lsu_we_i       <= we;
      lsu_type_i     <= typ;
      lsu_addr_i     <= addr;
      lsu_wdata_i    <= $urandom;
      lsu_sign_ext_i <= sext;
      t = 0;
      do begin
        @(negedge clk_i);
        t++;
      end while (!lsu_req_done_o && t < MaxWait);
      @(posedge clk_i);
      lsu_req_i <= 1'b0;
      if (t >= MaxWait) begin
        $display("timeout: access at %h was never completed by the unit", addr);
        timed_out = 1'b1;
      end else begin
        t = 0;
        do begin
          @(negedge clk_i);
          t++;
        end while (!lsu_resp_valid_o && t < MaxWait);
        if (t >= MaxWait) begin
          $display("timeout: no response arrived for access at %h", addr);
          timed_out = 1'b1;
        end
      end
    end
  endtask

  // address in the small working window, aligned to the access size
  function automatic logic [31:0] aligned_addr(input logic [1:0] typ);
    logic [31:0] a;
    a = BaseAddr + ($urandom % 32);
    if (typ == 2'd0) a[1:0] = 2'b00;
    else if (typ == 2'd1) a[0] = 1'b0;
    return a;
  endfunction

  task automatic end_test(input int n);
    @(posedge clk_i);
    test_num_i <= n;
    test_end_i <= 1'b1;
    @(posedge clk_i);
    test_end_i <= 1'b0;
  endtask

  initial begin
    logic [1:0]  typ;
    logic [31:0] a;
    void'($urandom(Seed));
    rst_ni         = 1'b0;
    lsu_req_i      = 1'b0;
    lsu_we_i       = 1'b0;
    lsu_type_i     = 2'd0;
    lsu_addr_i     = 32'h0;
    lsu_wdata_i    = 32'h0;
    lsu_sign_ext_i = 1'b0;
    test_end_i     = 1'b0;
    test_num_i     = 0;
    timed_out      = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    // idle outputs are checked right after reset
    repeat (3) @(posedge clk_i);
    end_test(1);

    // aligned store followed by a load of the same place
    for (int i = 0; i < 24 && !timed_out; i++) begin
      typ = 2'($urandom % 4);
      a   = aligned_addr(typ);
      run_access(1'b1, typ, a, 1'b0);
      run_access(1'b0, typ, a, 1'($urandom));
    end
    end_test(2);

    // loads of any size, extension on and off
    for (int i = 0; i < 30 && !timed_out; i++) begin
      typ = 2'($urandom % 4);
      run_access(1'b0, typ, aligned_addr(typ), 1'($urandom));
    end
    end_test(3);

    // word crossing: word at offset 1..3, half at offset 3
    for (int i = 0; i < 24 && !timed_out; i++) begin
      typ = 2'($urandom % 2);
      a   = {BaseAddr[31:5] + 27'($urandom % 2), 3'($urandom), 2'b11};
      if (typ == 2'd0) a[1:0] = 2'(1 + $urandom % 3);
      run_access(1'b1, typ, a, 1'b0);
      run_access(1'b0, typ, a, 1'($urandom));
    end
    end_test(4);

    // random mix of everything
    for (int i = 0; i < 100 && !timed_out; i++) begin
      run_access(1'($urandom), 2'($urandom), BaseAddr + ($urandom % 32), 1'($urandom));
    end
    end_test(5);

    // window straddling the start of the error region
    for (int i = 0; i < 30 && !timed_out; i++) begin
      a = 32'hEFFF_FFF8 + ($urandom % 16);
      run_access(1'($urandom), 2'($urandom), a, 1'($urandom));
    end
    end_test(6);

    repeat (2) @(posedge clk_i);
    $display("total: %0d checks, %0d failures", check_count, error_count);
    if (timed_out || error_count != 0) begin
      $display("TESTBENCH FAILED");
    end else begin
      $display("TESTBENCH PASSED");
    end
    $finish;
  end

endmodule

// File: logic/lsu_ctrl_if.sv
// control strobes between the LSU FSM and the two data path blocks
`timescale 1ns/1ps

interface lsu_ctrl_if;

  // latch offset, type and sign flag of the access
  logic ctrl_update;
  // latch the address reported on addr_last_o
  logic addr_update;
  // capture the upper bytes of the first response
  logic rdata_update;
  // address and byte enables refer to the second word
  logic second_half;
  // access crosses a word boundary
  logic split;

  modport fsm (
    output ctrl_update,
    output addr_update,
    output rdata_update,
    output second_half,
    input  split
  );

  modport req (
    input  addr_update,
    input  second_half,
    output split
  );

  modport rdata (
    input  ctrl_update,
    input  rdata_update
  );

endinterface

// File: logic/lsu_fsm.sv
// request / grant / response FSM of the load/store unit
// first-half error and write flag registers, response qualification
`timescale 1ns/1ps

module lsu_fsm (
  input  logic        clk_i,
  input  logic        rst_ni,

  // execute side
  input  logic        lsu_req_i,
  input  logic        lsu_we_i,
  output logic        lsu_req_done_o,
  output logic        lsu_resp_valid_o,
  output logic        lsu_rdata_valid_o,
  output logic        load_err_o,
  output logic        store_err_o,
  output logic        busy_o,

  // memory side
  output logic        data_req_o,
  input  logic        data_gnt_i,
  input  logic        data_rvalid_i,
  input  logic        data_bus_err_i,

  lsu_ctrl_if.fsm     ctrl
);

  lsu_pkg::lsu_state_e ls_cs, ls_ns;

  // high once the first part of a split access is granted
  logic handle_mis_q, handle_mis_d;
  // bus error seen on the first part
  logic lsu_err_q, lsu_err_d;
  logic data_we_q;
  logic any_err;

  //////////////////////////////
  // next state
  //////////////////////////////

  always_comb begin
    ls_ns             = ls_cs;
    handle_mis_d      = handle_mis_q;
    lsu_err_d         = lsu_err_q;
    data_req_o        = 1'b0;
    ctrl.ctrl_update  = 1'b0;
    ctrl.addr_update  = 1'b0;
    ctrl.rdata_update = 1'b0;
    ctrl.second_half  = 1'b0;

    case (ls_cs)
      lsu_pkg::LS_IDLE: begin
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          lsu_err_d  = 1'b0;
          if (data_gnt_i) begin
            ctrl.ctrl_update = 1'b1;
            ctrl.addr_update = 1'b1;
            handle_mis_d     = ctrl.split;
            ls_ns = ctrl.split ? lsu_pkg::LS_WAIT_RVALID_MIS : lsu_pkg::LS_IDLE;
          end else begin
            ls_ns = ctrl.split ? lsu_pkg::LS_WAIT_GNT_MIS : lsu_pkg::LS_WAIT_GNT;
          end
        end
      end

      // first part of a split access still waiting
      lsu_pkg::LS_WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl.ctrl_update = 1'b1;
          ctrl.addr_update = 1'b1;
          handle_mis_d     = 1'b1;
          ls_ns            = lsu_pkg::LS_WAIT_RVALID_MIS;
        end
      end

      // second request goes out while the first response is pending
      lsu_pkg::LS_WAIT_RVALID_MIS: begin
        data_req_o       = 1'b1;
        ctrl.second_half = 1'b1;
        if (data_rvalid_i) begin
          lsu_err_d         = data_bus_err_i;
          ctrl.rdata_update = ~data_we_q;
          // keep the first failing address
          ctrl.addr_update  = data_gnt_i & ~data_bus_err_i;
          handle_mis_d      = ~data_gnt_i;
          ls_ns = data_gnt_i ? lsu_pkg::LS_IDLE : lsu_pkg::LS_WAIT_GNT;
        end else if (data_gnt_i) begin
          handle_mis_d = 1'b0;
          ls_ns        = lsu_pkg::LS_WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      // aligned access, or second part after its first response
      lsu_pkg::LS_WAIT_GNT: begin
        data_req_o       = 1'b1;
        ctrl.second_half = handle_mis_q;
        if (data_gnt_i) begin
          ctrl.ctrl_update = 1'b1;
          ctrl.addr_update = ~lsu_err_q;
          handle_mis_d     = 1'b0;
          ls_ns            = lsu_pkg::LS_IDLE;
        end
      end

      // both granted, first response outstanding
      lsu_pkg::LS_WAIT_RVALID_MIS_GNTS_DONE: begin
        ctrl.second_half = 1'b1;
        if (data_rvalid_i) begin
          lsu_err_d         = data_bus_err_i;
          ctrl.addr_update  = ~data_bus_err_i;
          ctrl.rdata_update = ~data_we_q;
          ls_ns             = lsu_pkg::LS_IDLE;
        end
      end

      default: ls_ns = lsu_pkg::LS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ls_cs        <= lsu_pkg::LS_IDLE;
      handle_mis_q <= 1'b0;
      lsu_err_q    <= 1'b0;
    end else begin
      ls_cs        <= ls_ns;
      handle_mis_q <= handle_mis_d;
      lsu_err_q    <= lsu_err_d;
    end
  end

  // write flag of the outstanding access, taken at grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_we_q <= 1'b0;
    end else if (ctrl.ctrl_update) begin
      data_we_q <= lsu_we_i;
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////

  // done as soon as nothing is left to be granted
  assign lsu_req_done_o = (lsu_req_i | (ls_cs != lsu_pkg::LS_IDLE)) &
                          (ls_ns == lsu_pkg::LS_IDLE);

  // final response always lands back in idle
  assign any_err           = lsu_err_q | data_bus_err_i;
  assign lsu_resp_valid_o  = data_rvalid_i & (ls_cs == lsu_pkg::LS_IDLE);
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~any_err & ~data_we_q;
  assign load_err_o        = lsu_resp_valid_o & any_err & ~data_we_q;
  assign store_err_o       = lsu_resp_valid_o & any_err & data_we_q;
  assign busy_o            = (ls_cs != lsu_pkg::LS_IDLE);

  a_state_legal : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ls_cs inside {lsu_pkg::LS_IDLE, lsu_pkg::LS_WAIT_GNT_MIS, lsu_pkg::LS_WAIT_RVALID_MIS,
                  lsu_pkg::LS_WAIT_GNT, lsu_pkg::LS_WAIT_RVALID_MIS_GNTS_DONE});

  // a pending access only completes on bus activity
  a_done_needs_bus : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (busy_o && lsu_req_done_o) |-> (data_gnt_i || data_rvalid_i));

endmodule

// File: logic/lsu_pkg.sv
// shared constants for the load/store unit
// access type and FSM state encodings
// byte enable helpers for first and second bus words
package lsu_pkg;

  // bus and register data width
  parameter int unsigned DataWidth = 32;
  parameter int unsigned BeWidth   = DataWidth / 8;

  // 2 and 3 both select a byte access
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  typedef enum logic [2:0] {
    LS_IDLE,
    LS_WAIT_GNT_MIS,
    LS_WAIT_RVALID_MIS,
    LS_WAIT_GNT,
    LS_WAIT_RVALID_MIS_GNTS_DONE
  } lsu_state_e;

  // lanes of the first word, the access shifted up by the byte offset
  function automatic logic [BeWidth-1:0] be_first(lsu_type_e t, logic [1:0] off);
    logic [BeWidth-1:0] base;
    case (t)
      LSU_WORD: base = 4'b1111;
      LSU_HALF: base = 4'b0011;
      default:  base = 4'b0001;
    endcase
    return base << off;
  endfunction

  // lanes spilling into the next word
  function automatic logic [BeWidth-1:0] be_second(lsu_type_e t, logic [1:0] off);
    logic [BeWidth-1:0] mask;
    case (t)
      // offset 0 shifts everything out, never issued
      LSU_WORD: mask = 4'b1111 >> (3'd4 - {1'b0, off});
      // only offset 3 splits a half word
      LSU_HALF: mask = 4'b0001;
      default:  mask = 4'b0001 << off;
    endcase
    return mask;
  endfunction

endpackage

// File: logic/lsu_rdata_align.sv
// load data realignment and zero / sign extension
// partial-word register and registered access attributes
`timescale 1ns/1ps

module lsu_rdata_align (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  input  logic [1:0]                       lsu_addr_i,
  input  lsu_pkg::lsu_type_e               lsu_type_i,
  input  logic                             lsu_sign_ext_i,
  input  logic [lsu_pkg::DataWidth-1:0]    data_rdata_i,

  output logic [lsu_pkg::DataWidth-1:0]    lsu_rdata_o,

  lsu_ctrl_if.rdata                        ctrl
);

  logic [1:0]                    offset_q;
  lsu_pkg::lsu_type_e            type_q;
  logic                          sign_ext_q;
  // upper three bytes of the first word of a split load
  logic [lsu_pkg::DataWidth-1:8] rdata_q;

  logic [lsu_pkg::DataWidth-1:0] word_val;
  logic [15:0]                   half_val;
  logic [7:0]                    byte_val;

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= 2'b00;
      type_q     <= lsu_pkg::LSU_WORD;
      sign_ext_q <= 1'b0;
    end else if (ctrl.ctrl_update) begin
      offset_q   <= lsu_addr_i;
      type_q     <= lsu_type_i;
      sign_ext_q <= lsu_sign_ext_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctrl.rdata_update) begin
      rdata_q <= data_rdata_i[31:8];
    end
  end

  //////////////////////////////
  // realignment
  //////////////////////////////

  // split word: low bytes come from the earlier response
  always_comb begin
    case (offset_q)
      2'b01:   word_val = {data_rdata_i[7:0],  rdata_q[31:8]};
      2'b10:   word_val = {data_rdata_i[15:0], rdata_q[31:16]};
      2'b11:   word_val = {data_rdata_i[23:0], rdata_q[31:24]};
      default: word_val = data_rdata_i;
    endcase
  end

  // half word in the top lane is the only split half
  always_comb begin
    case (offset_q)
      2'b01:   half_val = data_rdata_i[23:8];
      2'b10:   half_val = data_rdata_i[31:16];
      2'b11:   half_val = {data_rdata_i[7:0], rdata_q[31:24]};
      default: half_val = data_rdata_i[15:0];
    endcase
  end

  assign byte_val = data_rdata_i[8*offset_q +: 8];

  // extension by type, sign taken from the top bit of the value
  always_comb begin
    case (type_q)
      lsu_pkg::LSU_WORD: lsu_rdata_o = word_val;
      lsu_pkg::LSU_HALF: lsu_rdata_o = {{16{sign_ext_q & half_val[15]}}, half_val};
      default:           lsu_rdata_o = {{24{sign_ext_q & byte_val[7]}}, byte_val};
    endcase
  end

  a_type_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(type_q));

  // partial data is only captured for an access that crosses a word
  a_capture_split : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ctrl.rdata_update |-> (offset_q != 2'b00));

endmodule

// File: logic/lsu_req_align.sv
// bus address, byte enable and write data generation
// split detection and the last-address register
`timescale 1ns/1ps

module lsu_req_align #(
  parameter int unsigned AddrWidth = 32
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  input  logic [AddrWidth-1:0]             lsu_addr_i,
  input  lsu_pkg::lsu_type_e               lsu_type_i,
  input  logic [lsu_pkg::DataWidth-1:0]    lsu_wdata_i,

  output logic [AddrWidth-1:0]             data_addr_o,
  output logic [lsu_pkg::BeWidth-1:0]      data_be_o,
  output logic [lsu_pkg::DataWidth-1:0]    data_wdata_o,
  output logic [AddrWidth-1:0]             addr_last_o,

  lsu_ctrl_if.req                          ctrl
);

  logic [1:0]           offset;
  logic [AddrWidth-1:0] addr_aligned;
  logic [AddrWidth-1:0] addr_next;
  logic [AddrWidth-1:0] addr_last_d;
  logic [AddrWidth-1:0] addr_last_q;

  assign offset = lsu_addr_i[1:0];

  // word crossing: unaligned word, or half word in the top lane
  assign ctrl.split = ((lsu_type_i == lsu_pkg::LSU_WORD) && (offset != 2'b00)) ||
                      ((lsu_type_i == lsu_pkg::LSU_HALF) && (offset == 2'b11));

  //////////////////////////////
  // address
  //////////////////////////////

  assign addr_aligned = {lsu_addr_i[AddrWidth-1:2], 2'b00};
  // second part goes to the following word
  assign addr_next    = addr_aligned + AddrWidth'(4);
  assign data_addr_o  = ctrl.second_half ? addr_next : addr_aligned;

  //////////////////////////////
  // byte enables and wdata
  //////////////////////////////

  assign data_be_o = ctrl.second_half ? lsu_pkg::be_second(lsu_type_i, offset) :
                                        lsu_pkg::be_first(lsu_type_i, offset);

  // rotate left by the byte offset
  // upper bytes wrap to the low lanes for the second word
  always_comb begin
    case (offset)
      2'b01:   data_wdata_o = {lsu_wdata_i[23:0], lsu_wdata_i[31:24]};
      2'b10:   data_wdata_o = {lsu_wdata_i[15:0], lsu_wdata_i[31:16]};
      2'b11:   data_wdata_o = {lsu_wdata_i[7:0],  lsu_wdata_i[31:8]};
      default: data_wdata_o = lsu_wdata_i;
    endcase
  end

  //////////////////////////////
  // last address
  //////////////////////////////

  // byte address for the first part, word address of the second part
  assign addr_last_d = ctrl.second_half ? addr_next : lsu_addr_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_last_q <= '0;
    end else if (ctrl.addr_update) begin
      addr_last_q <= addr_last_d;
    end
  end

  assign addr_last_o = addr_last_q;

  a_addr_word : assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_addr_o[1:0] == 2'b00);

endmodule

// File: logic/lsu_top.sv
// load/store unit top level
// FSM, request alignment and load alignment joined by the control interface
`timescale 1ns/1ps

module lsu_top #(
  parameter int unsigned AddrWidth = 32
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // execute side
  input  logic                             lsu_req_i,
  input  logic                             lsu_we_i,
  input  logic [1:0]                       lsu_type_i,
  input  logic [AddrWidth-1:0]             lsu_addr_i,
  input  logic [lsu_pkg::DataWidth-1:0]    lsu_wdata_i,
  input  logic                             lsu_sign_ext_i,
  output logic [lsu_pkg::DataWidth-1:0]    lsu_rdata_o,
  output logic                             lsu_rdata_valid_o,
  output logic                             lsu_req_done_o,
  output logic                             lsu_resp_valid_o,
  output logic [AddrWidth-1:0]             addr_last_o,
  output logic                             load_err_o,
  output logic                             store_err_o,
  output logic                             busy_o,

  // data memory bus
  output logic                             data_req_o,
  input  logic                             data_gnt_i,
  input  logic                             data_rvalid_i,
  input  logic                             data_bus_err_i,
  output logic [AddrWidth-1:0]             data_addr_o,
  output logic                             data_we_o,
  output logic [lsu_pkg::BeWidth-1:0]      data_be_o,
  output logic [lsu_pkg::DataWidth-1:0]    data_wdata_o,
  input  logic [lsu_pkg::DataWidth-1:0]    data_rdata_i
);

  lsu_ctrl_if ctrl ();

  // direction is stable for the whole access
  assign data_we_o = lsu_we_i;

  lsu_fsm u_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .lsu_we_i          (lsu_we_i),
    .lsu_req_done_o    (lsu_req_done_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .busy_o            (busy_o),
    .data_req_o        (data_req_o),
    .data_gnt_i        (data_gnt_i),
    .data_rvalid_i     (data_rvalid_i),
    .data_bus_err_i    (data_bus_err_i),
    .ctrl              (ctrl.fsm)
  );

  lsu_req_align #(
    .AddrWidth (AddrWidth)
  ) u_req_align (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .lsu_addr_i   (lsu_addr_i),
    .lsu_type_i   (lsu_pkg::lsu_type_e'(lsu_type_i)),
    .lsu_wdata_i  (lsu_wdata_i),
    .data_addr_o  (data_addr_o),
    .data_be_o    (data_be_o),
    .data_wdata_o (data_wdata_o),
    .addr_last_o  (addr_last_o),
    .ctrl         (ctrl.req)
  );

  // only the byte offset matters for load alignment
  lsu_rdata_align u_rdata_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lsu_addr_i     (lsu_addr_i[1:0]),
    .lsu_type_i     (lsu_pkg::lsu_type_e'(lsu_type_i)),
    .lsu_sign_ext_i (lsu_sign_ext_i),
    .data_rdata_i   (data_rdata_i),
    .lsu_rdata_o    (lsu_rdata_o),
    .ctrl           (ctrl.rdata)
  );

endmodule

// File: run.sh
#!/bin/bash
# build and run the LSU testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu -f all.f -o sim_lsu \
  && ./obj_dir/sim_lsu 2>&1 | tee sim.log \
  || { echo "build or simulation error"; exit 1; }

grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0
